// File: logic/membus_macros.svh
// Bus widths, memory depth and slave read latency
`ifndef MEMBUS_MACROS_SVH
`define MEMBUS_MACROS_SVH

// Request and AXI address width
`define MEMBUS_ADDR_WD 32

// One 64-bit word per beat
`define MEMBUS_DATA_WD 64

// Byte strobe, zero means load
`define MEMBUS_STRB_WD 8

`define MEMBUS_ID_WD 4

// Word index is address bits 10 down to 3
`define MEMBUS_MEM_WORDS 256

// Cycles from AR handshake to rvalid
`define MEMBUS_READ_WAIT 3

`endif

// File: logic/membus_pkg.sv
// Arbiter state and request kind enums
`default_nettype none

package membus_pkg;

    // Arbiter control FSM
    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_READ,
        ARB_WRITE,
        ARB_RESP
    } arb_state_e;

    // Granted request, also selects the read ID
    typedef enum logic [1:0] {
        REQ_FETCH,
        REQ_LOAD,
        REQ_STORE
    } req_kind_e;

endpackage

`default_nettype wire

// File: logic/bus_arbiter.sv
// Two-port grant FSM with address mux and completion routing
`include "membus_macros.svh"
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         inst_en,
    input  logic [`MEMBUS_ADDR_WD-1:0]   inst_addr,
    output logic                         inst_ready,
    output logic                         inst_valid,
    input  logic                         data_en,
    input  logic [`MEMBUS_STRB_WD-1:0]   data_wen,
    input  logic [`MEMBUS_ADDR_WD-1:0]   data_addr,
    input  logic [`MEMBUS_DATA_WD-1:0]   data_wdata,
    output logic                         data_ready,
    output logic                         data_valid,
    output logic                         rd_start,
    output membus_pkg::req_kind_e        rd_kind,
    output logic [`MEMBUS_ADDR_WD-1:0]   rd_addr,
    input  logic                         rd_done,
    output logic                         wr_start,
    output logic [`MEMBUS_ADDR_WD-1:0]   wr_addr,
    output logic [`MEMBUS_DATA_WD-1:0]   wr_data,
    output logic [`MEMBUS_STRB_WD-1:0]   wr_strb,
    input  logic                         wr_done
);

    membus_pkg::arb_state_e state;
    membus_pkg::req_kind_e  kind;
    logic                   done;

    assign rd_kind = kind;
    assign done    = (state == membus_pkg::ARB_READ && rd_done) ||
                     (state == membus_pkg::ARB_WRITE && wr_done);

    // ------------------------------------------------------------------
    // Grant and completion
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= membus_pkg::ARB_IDLE;
            kind       <= membus_pkg::REQ_FETCH;
            inst_ready <= 1'b0;
            data_ready <= 1'b0;
            inst_valid <= 1'b0;
            data_valid <= 1'b0;
            rd_start   <= 1'b0;
            wr_start   <= 1'b0;
        end else begin
            inst_ready <= 1'b0;
            data_ready <= 1'b0;
            inst_valid <= 1'b0;
            data_valid <= 1'b0;
            rd_start   <= 1'b0;
            wr_start   <= 1'b0;
            case (state)
                membus_pkg::ARB_IDLE: begin
                    // Data port wins a tie
                    if (data_en) begin
                        data_ready <= 1'b1;
                        if (|data_wen) begin
                            kind     <= membus_pkg::REQ_STORE;
                            wr_start <= 1'b1;
                            state    <= membus_pkg::ARB_WRITE;
                        end else begin
                            kind     <= membus_pkg::REQ_LOAD;
                            rd_start <= 1'b1;
                            state    <= membus_pkg::ARB_READ;
                        end
                    end else if (inst_en) begin
                        kind       <= membus_pkg::REQ_FETCH;
                        inst_ready <= 1'b1;
                        rd_start   <= 1'b1;
                        state      <= membus_pkg::ARB_READ;
                    end
                end
                membus_pkg::ARB_READ, membus_pkg::ARB_WRITE: begin
                    if (done) begin
                        inst_valid <= (kind == membus_pkg::REQ_FETCH);
                        data_valid <= (kind != membus_pkg::REQ_FETCH);
                        state      <= membus_pkg::ARB_RESP;
                    end
                end
                default: begin
                    state <= membus_pkg::ARB_IDLE;
                end
            endcase
        end
    end

    // Request fields, latched with the grant
    always_ff @(posedge clk) begin
        if (state == membus_pkg::ARB_IDLE) begin
            if (data_en) begin
                rd_addr <= data_addr;
                wr_addr <= data_addr;
                wr_data <= data_wdata;
                wr_strb <= data_wen;
            end else if (inst_en) begin
                rd_addr <= inst_addr;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/axi_read_path.sv
// AXI4 AR and R channel master for one single-beat read
`include "membus_macros.svh"
`timescale 1ns/1ps
`default_nettype none

module axi_read_path (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         rd_start,
    input  membus_pkg::req_kind_e        rd_kind,
    input  logic [`MEMBUS_ADDR_WD-1:0]   rd_addr,
    output logic                         rd_done,
    output logic [`MEMBUS_DATA_WD-1:0]   rd_data,
    output logic [`MEMBUS_ID_WD-1:0]     arid,
    output logic [`MEMBUS_ADDR_WD-1:0]   araddr,
    output logic [7:0]                   arlen,
    output logic [2:0]                   arsize,
    output logic [1:0]                   arburst,
    output logic                         arvalid,
    input  logic                         arready,
    input  logic [`MEMBUS_ID_WD-1:0]     rid,
    input  logic [`MEMBUS_DATA_WD-1:0]   rdata,
    input  logic                         rlast,
    input  logic                         rvalid,
    output logic                         rready
);

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_ADDR,
        RD_DATA
    } rd_state_e;

    rd_state_e state;
    logic      r_hit;

    // Single beat, 8 bytes, INCR
    assign arlen   = 8'd0;
    assign arsize  = 3'd3;
    assign arburst = 2'b01;

    assign r_hit = rvalid && rready && rlast && (rid == arid);

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= RD_IDLE;
            arvalid <= 1'b0;
            rready  <= 1'b0;
            rd_done <= 1'b0;
        end else begin
            rd_done <= 1'b0;
            case (state)
                RD_IDLE: begin
                    if (rd_start) begin
                        arvalid <= 1'b1;
                        state   <= RD_ADDR;
                    end
                end
                RD_ADDR: begin
                    if (arready) begin
                        arvalid <= 1'b0;
                        rready  <= 1'b1;
                        state   <= RD_DATA;
                    end
                end
                default: begin
                    if (r_hit) begin
                        rready  <= 1'b0;
                        rd_done <= 1'b1;
                        state   <= RD_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == RD_IDLE && rd_start) begin
            // Fetch reads with ID 0, loads with ID 1
            arid   <= (rd_kind == membus_pkg::REQ_FETCH) ? `MEMBUS_ID_WD'(0) : `MEMBUS_ID_WD'(1);
            araddr <= rd_addr;
        end
        if (r_hit) begin
            rd_data <= rdata;
        end
    end

endmodule

`default_nettype wire

// File: logic/axi_write_path.sv
// AXI4 AW, W and B channel master for one single-beat write
`include "membus_macros.svh"
`timescale 1ns/1ps
`default_nettype none

module axi_write_path (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         wr_start,
    input  logic [`MEMBUS_ADDR_WD-1:0]   wr_addr,
    input  logic [`MEMBUS_DATA_WD-1:0]   wr_data,
    input  logic [`MEMBUS_STRB_WD-1:0]   wr_strb,
    output logic                         wr_done,
    output logic [`MEMBUS_ID_WD-1:0]     awid,
    output logic [`MEMBUS_ADDR_WD-1:0]   awaddr,
    output logic [7:0]                   awlen,
    output logic [2:0]                   awsize,
    output logic [1:0]                   awburst,
    output logic                         awvalid,
    input  logic                         awready,
    output logic [`MEMBUS_DATA_WD-1:0]   wdata,
    output logic [`MEMBUS_STRB_WD-1:0]   wstrb,
    output logic                         wlast,
    output logic                         wvalid,
    input  logic                         wready,
    input  logic [`MEMBUS_ID_WD-1:0]     bid,
    input  logic                         bvalid,
    output logic                         bready
);

    typedef enum logic [2:0] {
        WR_IDLE,
        WR_WAIT,
        WR_WAIT_W,
        WR_WAIT_AW,
        WR_RESP
    } wr_state_e;

    wr_state_e state;
    logic      aw_open;
    logic      w_open;

    // Stores are always data accesses
    assign awid    = `MEMBUS_ID_WD'(1);
    assign awlen   = 8'd0;
    assign awsize  = 3'd3;
    assign awburst = 2'b01;
    assign wlast   = 1'b1;

    // Channel still pending after this edge
    assign aw_open = awvalid && !awready;
    assign w_open  = wvalid && !wready;

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= WR_IDLE;
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
            bready  <= 1'b0;
            wr_done <= 1'b0;
        end else begin
            wr_done <= 1'b0;
            case (state)
                WR_IDLE: begin
                    if (wr_start) begin
                        awvalid <= 1'b1;
                        wvalid  <= 1'b1;
                        state   <= WR_WAIT;
                    end
                end
                WR_WAIT, WR_WAIT_W, WR_WAIT_AW: begin
                    awvalid <= aw_open;
                    wvalid  <= w_open;
                    if (!aw_open && !w_open) begin
                        bready <= 1'b1;
                        state  <= WR_RESP;
                    end else if (!aw_open) begin
                        state <= WR_WAIT_W;
                    end else if (!w_open) begin
                        state <= WR_WAIT_AW;
                    end
                end
                default: begin
                    if (bvalid && bid == awid) begin
                        bready  <= 1'b0;
                        wr_done <= 1'b1;
                        state   <= WR_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == WR_IDLE && wr_start) begin
            awaddr <= wr_addr;
            wdata  <= wr_data;
            wstrb  <= wr_strb;
        end
    end

endmodule

`default_nettype wire

// File: logic/axi_sram.sv
// Single-beat AXI4 slave memory with read wait and byte-strobe writes
`include "membus_macros.svh"
`timescale 1ns/1ps
`default_nettype none

module axi_sram (
    input  logic                         clk,
    input  logic                         reset,
    input  logic [`MEMBUS_ID_WD-1:0]     arid,
    input  logic [`MEMBUS_ADDR_WD-1:0]   araddr,
    input  logic [7:0]                   arlen,
    input  logic [2:0]                   arsize,
    input  logic [1:0]                   arburst,
    input  logic                         arvalid,
    output logic                         arready,
    output logic [`MEMBUS_ID_WD-1:0]     rid,
    output logic [`MEMBUS_DATA_WD-1:0]   rdata,
    output logic [1:0]                   rresp,
    output logic                         rlast,
    output logic                         rvalid,
    input  logic                         rready,
    input  logic [`MEMBUS_ID_WD-1:0]     awid,
    input  logic [`MEMBUS_ADDR_WD-1:0]   awaddr,
    input  logic [7:0]                   awlen,
    input  logic [2:0]                   awsize,
    input  logic [1:0]                   awburst,
    input  logic                         awvalid,
    output logic                         awready,
    input  logic [`MEMBUS_DATA_WD-1:0]   wdata,
    input  logic [`MEMBUS_STRB_WD-1:0]   wstrb,
    input  logic                         wlast,
    input  logic                         wvalid,
    output logic                         wready,
    output logic [`MEMBUS_ID_WD-1:0]     bid,
    output logic [1:0]                   bresp,
    output logic                         bvalid,
    input  logic                         bready
);

    localparam int IDX_WD = $clog2(`MEMBUS_MEM_WORDS);
    localparam int CNT_WD = $clog2(`MEMBUS_READ_WAIT + 1);

    logic [`MEMBUS_DATA_WD-1:0] mem [`MEMBUS_MEM_WORDS];

    logic              rd_busy;
    logic [CNT_WD-1:0] rd_cnt;
    logic [IDX_WD-1:0] rd_idx;
    logic              rd_ok;
    logic              aw_held;
    logic [IDX_WD-1:0] wr_idx;
    logic              wr_ok;
    logic              ar_hs;
    logic              aw_hs;
    logic              w_hs;

    assign arready = !rd_busy;
    assign awready = !aw_held && !bvalid;
    assign wready  = aw_held;
    assign ar_hs   = arvalid && arready;
    assign aw_hs   = awvalid && awready;
    assign w_hs    = wvalid && wready;

    // Only single 8-byte INCR beats are served, anything else gets SLVERR
    assign rlast = 1'b1;
    assign rresp = rd_ok ? 2'b00 : 2'b10;
    assign bresp = wr_ok ? 2'b00 : 2'b10;

    // ------------------------------------------------------------------
    // Channel control
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_busy <= 1'b0;
            rd_cnt  <= '0;
            rvalid  <= 1'b0;
            aw_held <= 1'b0;
            bvalid  <= 1'b0;
        end else begin
            if (ar_hs) begin
                rd_busy <= 1'b1;
                rd_cnt  <= CNT_WD'(`MEMBUS_READ_WAIT);
            end else if (rd_cnt != '0) begin
                rd_cnt <= rd_cnt - 1'b1;
                rvalid <= (rd_cnt == CNT_WD'(1));
            end else if (rvalid && rready) begin
                rvalid  <= 1'b0;
                rd_busy <= 1'b0;
            end
            if (aw_hs) begin
                aw_held <= 1'b1;
            end else if (w_hs) begin
                aw_held <= 1'b0;
                bvalid  <= 1'b1;
            end else if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    // ------------------------------------------------------------------
    // Word array and response payload
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (ar_hs) begin
            rid    <= arid;
            rd_idx <= araddr[IDX_WD+2:3];
            rd_ok  <= arlen == 8'd0 && arsize == 3'd3 && arburst == 2'b01;
        end
        if (rd_cnt == CNT_WD'(1)) begin
            rdata <= mem[rd_idx];
        end
        if (aw_hs) begin
            bid    <= awid;
            wr_idx <= awaddr[IDX_WD+2:3];
            wr_ok  <= awlen == 8'd0 && awsize == 3'd3 && awburst == 2'b01;
        end
        if (w_hs) begin
            wr_ok <= wr_ok && wlast;
            for (int i = 0; i < `MEMBUS_STRB_WD; i++) begin
                if (wstrb[i]) begin
                    mem[wr_idx][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/membus_top.sv
// Memory subsystem top with arbiter, AXI read and write paths and SRAM
`include "membus_macros.svh"
`timescale 1ns/1ps
`default_nettype none

module membus_top (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         inst_en,
    input  logic [`MEMBUS_ADDR_WD-1:0]   inst_addr,
    output logic                         inst_ready,
    output logic                         inst_valid,
    output logic [`MEMBUS_DATA_WD-1:0]   inst_rdata,
    input  logic                         data_en,
    input  logic [`MEMBUS_STRB_WD-1:0]   data_wen,
    input  logic [`MEMBUS_ADDR_WD-1:0]   data_addr,
    input  logic [`MEMBUS_DATA_WD-1:0]   data_wdata,
    output logic                         data_ready,
    output logic                         data_valid,
    output logic [`MEMBUS_DATA_WD-1:0]   data_rdata
);

    logic                       rd_start, rd_done, wr_start, wr_done;
    membus_pkg::req_kind_e      rd_kind;
    logic [`MEMBUS_ADDR_WD-1:0] rd_addr, wr_addr;
    logic [`MEMBUS_DATA_WD-1:0] rd_data, wr_data;
    logic [`MEMBUS_STRB_WD-1:0] wr_strb;

    // AXI4 between the paths and the memory
    logic [`MEMBUS_ID_WD-1:0]   arid, rid, awid, bid;
    logic [`MEMBUS_ADDR_WD-1:0] araddr, awaddr;
    logic [7:0]                 arlen, awlen;
    logic [2:0]                 arsize, awsize;
    logic [1:0]                 arburst, awburst;
    logic                       arvalid, arready, rlast, rvalid, rready;
    logic                       awvalid, awready, wlast, wvalid, wready, bvalid, bready;
    logic [`MEMBUS_DATA_WD-1:0] rdata, wdata;
    logic [`MEMBUS_STRB_WD-1:0] wstrb;

    // One read register serves both ports
    assign inst_rdata = rd_data;
    assign data_rdata = rd_data;

    bus_arbiter u_bus_arbiter (.*);

    axi_read_path u_axi_read_path (.*);

    axi_write_path u_axi_write_path (.*);

    // Responses are not checked by the masters
    axi_sram u_axi_sram (
        .rresp (),
        .bresp (),
        .*
    );

endmodule

`default_nettype wire

// File: dv/membus_assertions.sv
// Concurrent checks on AXI valid hold, port pulses and reset state
`timescale 1ns/1ps
`default_nettype none

module membus_assertions (
    input logic clk,
    input logic reset,
    input logic inst_ready,
    input logic inst_valid,
    input logic data_ready,
    input logic data_valid,
    input logic arvalid,
    input logic arready,
    input logic awvalid,
    input logic awready
);

    // AXI valid stays up until accepted
    ar_hold: assert property (@(posedge clk) disable iff (reset)
        arvalid && !arready |=> arvalid)
        else $error("arvalid dropped before the AR handshake");

    aw_hold: assert property (@(posedge clk) disable iff (reset)
        awvalid && !awready |=> awvalid)
        else $error("awvalid dropped before the AW handshake");

    valid_excl: assert property (@(posedge clk) disable iff (reset)
        !(inst_valid && data_valid))
        else $error("inst_valid and data_valid high together");

    inst_ready_pulse: assert property (@(posedge clk) disable iff (reset)
        inst_ready |=> !inst_ready)
        else $error("inst_ready longer than one cycle");

    data_ready_pulse: assert property (@(posedge clk) disable iff (reset)
        data_ready |=> !data_ready)
        else $error("data_ready longer than one cycle");

    reset_quiet: assert property (@(posedge clk)
        $past(reset) |-> !(inst_ready || inst_valid || data_ready || data_valid))
        else $error("Port handshake active during reset");

endmodule

bind membus_top membus_assertions u_membus_assertions (
    .clk        (clk),
    .reset      (reset),
    .inst_ready (inst_ready),
    .inst_valid (inst_valid),
    .data_ready (data_ready),
    .data_valid (data_valid),
    .arvalid    (arvalid),
    .arready    (arready),
    .awvalid    (awvalid),
    .awready    (awready)
);

`default_nettype wire

// File: dv/membus_tb.sv
// Memory subsystem testbench with stimulus table, reference memory, checker and timeout
`include "membus_macros.svh"
`timescale 1ns/1ps
`default_nettype none

module membus_tb;

    localparam int          RESET_CYCLES   = 8;
    localparam int          DRIVE_DELAY    = 1;
    localparam int          N_DIRECTED     = 11;
    localparam int          N_RANDOM       = 200;
    localparam int          TABLE_LEN      = N_DIRECTED + N_RANDOM;
    localparam int          TIMEOUT_CYCLES = TABLE_LEN * 40 + 100;
    localparam int unsigned SEED           = 32'h704d3714;

    localparam int KIND_FETCH = 0;
    localparam int KIND_LOAD  = 1;
    localparam int KIND_STORE = 2;

    typedef logic [`MEMBUS_ADDR_WD-1:0] addr_t;
    typedef logic [`MEMBUS_DATA_WD-1:0] data_t;
    typedef logic [`MEMBUS_STRB_WD-1:0] strb_t;

    // A pair entry is a data request raised together with the next fetch
    typedef struct {
        int    kind;
        bit    pair;
        bit    directed;
        addr_t addr;
        data_t wdata;
        strb_t strb;
        data_t expect_data;
    } entry_t;

    logic  clk;
    logic  reset;
    logic  inst_en;
    addr_t inst_addr;
    logic  inst_ready;
    logic  inst_valid;
    data_t inst_rdata;
    logic  data_en;
    strb_t data_wen;
    addr_t data_addr;
    data_t data_wdata;
    logic  data_ready;
    logic  data_valid;
    data_t data_rdata;

    entry_t      stim [TABLE_LEN];
    data_t       model_mem [`MEMBUS_MEM_WORDS];
    bit          touched [`MEMBUS_MEM_WORDS];
    int          fill_idx;
    int          inst_count;
    int          data_count;
    int          inst_expected;
    int          data_expected;
    int          cycle_count;
    int          pos;

    membus_top u_membus_top (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the stimulus table did not complete", cycle_count);
            $display("TEST FAIL");
            $fatal(1, "Simulation timeout");
        end
    end

    // Response pulse counters
    always @(negedge clk) begin
        if (inst_valid) begin
            inst_count = inst_count + 1;
        end
        if (data_valid) begin
            data_count = data_count + 1;
        end
    end

    task automatic check_value(input string name, input data_t got, input data_t want);
        if (got !== want) begin
            $display("Fail at %0d ns: %s got %h expected %h", $time, name, got, want);
            $display("TEST FAIL");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    // ------------------------------------------------------------------
    // Reference memory and stimulus table
    // ------------------------------------------------------------------
    function automatic int word_index(input addr_t addr);
        return int'(addr[10:3]);
    endfunction

    task automatic apply_store(input addr_t addr, input data_t wdata, input strb_t strb);
        int idx;
        idx = word_index(addr);
        for (int b = 0; b < `MEMBUS_STRB_WD; b++) begin
            if (strb[b]) begin
                model_mem[idx][8*b +: 8] = wdata[8*b +: 8];
            end
        end
    endtask

    task automatic add_entry(input int kind, input bit pair, input addr_t addr,
                             input data_t wdata, input strb_t strb, input data_t expect_data);
        stim[fill_idx].kind        = kind;
        stim[fill_idx].pair        = pair;
        stim[fill_idx].directed    = 1'b1;
        stim[fill_idx].addr        = addr;
        stim[fill_idx].wdata       = wdata;
        stim[fill_idx].strb        = strb;
        stim[fill_idx].expect_data = expect_data;
        if (kind == KIND_STORE && strb == '1) begin
            touched[word_index(addr)] = 1'b1;
        end
        fill_idx++;
    endtask

    task automatic build_random();
        int    kind;
        int    idx;
        addr_t addr;
        strb_t strb;
        data_t wdata;
        for (int n = 0; n < N_RANDOM; n++) begin
            kind  = int'($urandom % 3);
            idx   = 64 + int'($urandom % 32);
            addr  = ($urandom & 32'hffff_f800) | addr_t'(idx << 3);
            wdata = {$urandom, $urandom};
            strb  = strb_t'($urandom % 255 + 1);
            // First access to a word is a full store
            if (!touched[idx]) begin
                kind = KIND_STORE;
                strb = '1;
            end
            if (kind != KIND_STORE) begin
                strb = '0;
            end
            add_entry(kind, 1'b0, addr, wdata, strb, '0);
            stim[fill_idx-1].directed = 1'b0;
        end
    endtask

    // Walk the table in issue order, random reads take the model value
    task automatic predict_all();
        for (int i = 0; i < `MEMBUS_MEM_WORDS; i++) begin
            model_mem[i] = '0;
        end
        for (int i = 0; i < TABLE_LEN; i++) begin
            if (stim[i].kind == KIND_STORE) begin
                apply_store(stim[i].addr, stim[i].wdata, stim[i].strb);
            end else if (!stim[i].directed) begin
                stim[i].expect_data = model_mem[word_index(stim[i].addr)];
            end
        end
    endtask

    // ------------------------------------------------------------------
    // Request drivers
    // ------------------------------------------------------------------
    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic check_port_outputs_low();
        check_value("inst_ready", data_t'(inst_ready), '0);
        check_value("inst_valid", data_t'(inst_valid), '0);
        check_value("data_ready", data_t'(data_ready), '0);
        check_value("data_valid", data_t'(data_valid), '0);
    endtask

    task automatic check_response_counts();
        check_value("inst_valid_count", data_t'(inst_count), data_t'(inst_expected));
        check_value("data_valid_count", data_t'(data_count), data_t'(data_expected));
    endtask

    task automatic run_single(input entry_t e);
        bit is_fetch;
        bit got_ready;
        bit got_valid;
        is_fetch  = (e.kind == KIND_FETCH);
        got_ready = 1'b0;
        got_valid = 1'b0;
        if (is_fetch) begin
            inst_en   = 1'b1;
            inst_addr = e.addr;
        end else begin
            data_en    = 1'b1;
            data_addr  = e.addr;
            data_wdata = e.wdata;
            data_wen   = e.strb;
        end
        while (!got_valid) begin
            next_cycle();
            if (inst_ready || data_ready) begin
                check_value("data_ready", data_t'(data_ready), data_t'(!is_fetch));
                check_value("inst_ready", data_t'(inst_ready), data_t'(is_fetch));
                got_ready = 1'b1;
                inst_en   = 1'b0;
                data_en   = 1'b0;
            end
            if (inst_valid || data_valid) begin
                check_value("ready_before_valid", data_t'(got_ready), data_t'(1));
                check_value("inst_valid", data_t'(inst_valid), data_t'(is_fetch));
                check_value("data_valid", data_t'(data_valid), data_t'(!is_fetch));
                got_valid = 1'b1;
            end
        end
        if (is_fetch) begin
            check_value("inst_rdata", inst_rdata, e.expect_data);
            inst_expected++;
        end else begin
            if (e.kind == KIND_LOAD) begin
                check_value("data_rdata", data_rdata, e.expect_data);
            end
            data_expected++;
        end
        next_cycle();
        check_response_counts();
    endtask

    // Data entry d and fetch entry f raised in the same cycle
    task automatic run_pair(input entry_t d, input entry_t f);
        int cyc;
        int data_ready_at;
        int inst_ready_at;
        bit data_done;
        bit inst_done;
        cyc           = 0;
        data_ready_at = -1;
        inst_ready_at = -1;
        data_done     = 1'b0;
        inst_done     = 1'b0;
        inst_en       = 1'b1;
        inst_addr     = f.addr;
        data_en       = 1'b1;
        data_addr     = d.addr;
        data_wdata    = d.wdata;
        data_wen      = d.strb;
        while (!(data_done && inst_done)) begin
            next_cycle();
            cyc++;
            if (data_ready) begin
                data_ready_at = cyc;
                data_en       = 1'b0;
            end
            if (inst_ready) begin
                inst_ready_at = cyc;
                inst_en       = 1'b0;
            end
            if (data_valid) begin
                data_done = 1'b1;
                if (d.kind == KIND_LOAD) begin
                    check_value("data_rdata", data_rdata, d.expect_data);
                end
            end
            if (inst_valid) begin
                inst_done = 1'b1;
                check_value("inst_rdata", inst_rdata, f.expect_data);
            end
        end
        check_value("data_ready_first",
                    data_t'(data_ready_at > 0 && data_ready_at < inst_ready_at), data_t'(1));
        inst_expected++;
        data_expected++;
        next_cycle();
        check_response_counts();
    endtask

    initial begin
        void'($urandom(SEED));
        reset      = 1'b1;
        inst_en    = 1'b0;
        inst_addr  = '0;
        data_en    = 1'b0;
        data_wen   = '0;
        data_addr  = '0;
        data_wdata = '0;

        add_entry(KIND_STORE, 1'b0, 32'h0000_0100, 64'h0123_4567_89ab_cdef, 8'hff, '0);
        add_entry(KIND_LOAD,  1'b0, 32'h0000_0100, '0, 8'h00, 64'h0123_4567_89ab_cdef);
        add_entry(KIND_STORE, 1'b0, 32'h0000_0100, 64'hffee_ddcc_bbaa_9988, 8'h0f, '0);
        add_entry(KIND_LOAD,  1'b0, 32'h0000_0100, '0, 8'h00, 64'h0123_4567_bbaa_9988);
        add_entry(KIND_STORE, 1'b0, 32'h0000_0100, 64'h1122_3344_5566_7788, 8'ha5, '0);
        add_entry(KIND_FETCH, 1'b0, 32'h0000_0100, '0, 8'h00, 64'h1123_3367_bb66_9988);
        // Bit 11 and up fall outside the memory
        add_entry(KIND_LOAD,  1'b0, 32'h0000_0900, '0, 8'h00, 64'h1123_3367_bb66_9988);
        add_entry(KIND_STORE, 1'b1, 32'h0000_0300, 64'hcafe_f00d_dead_beef, 8'hff, '0);
        add_entry(KIND_FETCH, 1'b0, 32'h0000_0300, '0, 8'h00, 64'hcafe_f00d_dead_beef);
        add_entry(KIND_LOAD,  1'b1, 32'h0000_0300, '0, 8'h00, 64'hcafe_f00d_dead_beef);
        add_entry(KIND_FETCH, 1'b0, 32'h0000_0100, '0, 8'h00, 64'h1123_3367_bb66_9988);
        build_random();
        predict_all();

        repeat (RESET_CYCLES) begin
            next_cycle();
            check_port_outputs_low();
        end
        reset = 1'b0;
        repeat (2) begin
            next_cycle();
            check_port_outputs_low();
        end

        pos = 0;
        while (pos < TABLE_LEN) begin
            if (stim[pos].pair) begin
                run_pair(stim[pos], stim[pos+1]);
                pos += 2;
            end else begin
                run_single(stim[pos]);
                pos += 1;
            end
        end
        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: membus.f
+incdir+logic
logic/membus_pkg.sv
logic/bus_arbiter.sv
logic/axi_read_path.sv
logic/axi_write_path.sv
logic/axi_sram.sv
logic/membus_top.sv
dv/membus_assertions.sv
dv/membus_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the memory subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module membus_tb -f membus.f \
    --Mdir obj_dir -o membus_sim

./obj_dir/membus_sim 2>&1 | tee sim.log

if grep -q "^TEST PASS$" sim.log; then
    echo "Simulation passed"
    exit 0
fi
echo "Simulation failed, see sim.log"
exit 1
